/* source/x86_opnd_pkg.sv */
package x86_opnd_pkg;

  // Data and address width of the 32-bit core
  localparam int WORD_W = 32;
  // Opcode byte plus at most ten body bytes
  localparam int INSTR_BYTES = 11;
  localparam int BODY_LEN_W = 4;

  // How the operands of an instruction are encoded
  typedef enum logic [3:0] {
    FORM_NONE,
    FORM_REG,
    FORM_IMM,
    FORM_REG_IMM,
    FORM_EAX_IMM,
    FORM_EAX_REG,
    FORM_RM,
    FORM_RM_REG,
    FORM_REG_RM,
    FORM_RM_IMM
  } opnd_form_e;

  // Register numbers in the order x86 encodes them
  typedef enum logic [2:0] {
    REG_EAX = 3'd0,
    REG_ECX = 3'd1,
    REG_EDX = 3'd2,
    REG_EBX = 3'd3,
    REG_ESP = 3'd4,
    REG_EBP = 3'd5,
    REG_ESI = 3'd6,
    REG_EDI = 3'd7
  } reg_sel_e;

  typedef enum logic [1:0] {
    DEST_NONE,
    DEST_REG,
    DEST_MEM
  } dest_kind_e;

  // Eight-way register read, used by every consumer of a register number
  function automatic logic [WORD_W-1:0] reg_read(
    input reg_sel_e          sel,
    input logic [WORD_W-1:0] eax,
    input logic [WORD_W-1:0] ecx,
    input logic [WORD_W-1:0] edx,
    input logic [WORD_W-1:0] ebx,
    input logic [WORD_W-1:0] esp,
    input logic [WORD_W-1:0] ebp,
    input logic [WORD_W-1:0] esi,
    input logic [WORD_W-1:0] edi
  );
    case (sel)
      REG_EAX: return eax;
      REG_ECX: return ecx;
      REG_EDX: return edx;
      REG_EBX: return ebx;
      REG_ESP: return esp;
      REG_EBP: return ebp;
      REG_ESI: return esi;
      default: return edi;
    endcase
  endfunction

endpackage

/* source/instr_field_parser.sv */
`timescale 1ns/10ps

module instr_field_parser
  import x86_opnd_pkg::*;
(
  input  logic [INSTR_BYTES*8-1:0] instr_bytes,
  input  opnd_form_e               opnd_form,
  input  logic                     imm_1byte,
  output logic [7:0]               modrm,
  output logic [7:0]               sib,
  output logic [WORD_W-1:0]        disp,
  output logic [WORD_W-1:0]        imm,
  output logic                     has_sib,
  output logic                     rm_is_reg,
  output logic                     rm_is_mem,
  output logic [BODY_LEN_W-1:0]    body_len
);

  logic                  has_modrm;
  logic                  has_imm;
  logic [1:0]            mod_bits;
  logic [BODY_LEN_W-1:0] disp_len;
  logic [BODY_LEN_W-1:0] imm_len;
  logic [BODY_LEN_W-1:0] disp_off;
  logic [BODY_LEN_W-1:0] imm_off;
  logic [WORD_W-1:0]     disp_raw;
  logic [WORD_W-1:0]     imm_raw;

  assign has_modrm = opnd_form inside {FORM_RM, FORM_RM_REG, FORM_REG_RM, FORM_RM_IMM};
  assign has_imm = opnd_form inside {FORM_IMM, FORM_REG_IMM, FORM_EAX_IMM, FORM_RM_IMM};

  // The ModR/M byte sits right after the opcode
  assign modrm = has_modrm ? instr_bytes[15:8] : 8'h00;
  assign mod_bits = modrm[7:6];
  assign rm_is_reg = has_modrm && (mod_bits == 2'b11);
  assign rm_is_mem = has_modrm && (mod_bits != 2'b11);

  // rm of 100 in a memory form escapes to a SIB byte
  assign has_sib = rm_is_mem && (modrm[2:0] == 3'b100);
  assign sib = has_sib ? instr_bytes[23:16] : 8'h00;

  always_comb begin
    disp_len = '0;
    if (rm_is_mem) begin
      if (mod_bits == 2'b01) begin
        disp_len = BODY_LEN_W'(1);
      end else if (mod_bits == 2'b10) begin
        disp_len = BODY_LEN_W'(4);
      end else if (!has_sib && modrm[2:0] == 3'b101) begin
        // Absolute disp32 with no base register
        disp_len = BODY_LEN_W'(4);
      end else if (has_sib && sib[2:0] == 3'b101) begin
        disp_len = BODY_LEN_W'(4);
      end
    end
  end

  assign imm_len = !has_imm ? '0 : (imm_1byte ? BODY_LEN_W'(1) : BODY_LEN_W'(4));

  // Byte offsets inside instr_bytes count the opcode as byte 0
  assign disp_off = BODY_LEN_W'(1) + BODY_LEN_W'(has_modrm) + BODY_LEN_W'(has_sib);
  assign imm_off = disp_off + disp_len;

  // A four-byte window is always taken and short fields use its low byte
  assign disp_raw = instr_bytes[8*disp_off +: WORD_W];
  assign imm_raw = instr_bytes[8*imm_off +: WORD_W];

  assign disp = (disp_len == BODY_LEN_W'(1)) ? {{24{disp_raw[7]}}, disp_raw[7:0]} :
                (disp_len == BODY_LEN_W'(4)) ? disp_raw : '0;
  assign imm = (imm_len == BODY_LEN_W'(1)) ? {{24{imm_raw[7]}}, imm_raw[7:0]} :
               (imm_len == BODY_LEN_W'(4)) ? imm_raw : '0;

  assign body_len = BODY_LEN_W'(has_modrm) + BODY_LEN_W'(has_sib) + disp_len + imm_len;

  // Form codes above FORM_RM_IMM are undefined and would decode as no operands
  always_comb begin
    assert (opnd_form <= FORM_RM_IMM)
      else $error("undefined operand form %0d", opnd_form);
  end

endmodule

/* source/reg_operand_select.sv */
`timescale 1ns/10ps

module reg_operand_select
  import x86_opnd_pkg::*;
(
  input  opnd_form_e        opnd_form,
  input  logic [2:0]        opcode_low,
  input  logic [7:0]        modrm,
  input  logic              rm_is_reg,
  input  logic [WORD_W-1:0] eax,
  input  logic [WORD_W-1:0] ecx,
  input  logic [WORD_W-1:0] edx,
  input  logic [WORD_W-1:0] ebx,
  input  logic [WORD_W-1:0] esp,
  input  logic [WORD_W-1:0] ebp,
  input  logic [WORD_W-1:0] esi,
  input  logic [WORD_W-1:0] edi,
  output reg_sel_e          opnd0_regsel,
  output reg_sel_e          opnd1_regsel,
  output logic              opnd0_is_reg,
  output logic              opnd1_is_reg,
  output logic [WORD_W-1:0] opnd0_regval,
  output logic [WORD_W-1:0] opnd1_regval
);

  reg_sel_e op_reg;
  reg_sel_e rm_reg;
  reg_sel_e reg_field;

  // The three places a register number can come from
  assign op_reg = reg_sel_e'(opcode_low);
  assign rm_reg = reg_sel_e'(modrm[2:0]);
  assign reg_field = reg_sel_e'(modrm[5:3]);

  always_comb begin
    opnd0_regsel = REG_EAX;
    opnd0_is_reg = 1'b0;
    case (opnd_form)
      FORM_REG, FORM_REG_IMM: begin
        opnd0_regsel = op_reg;
        opnd0_is_reg = 1'b1;
      end
      // Accumulator forms keep the EAX default
      FORM_EAX_IMM, FORM_EAX_REG: begin
        opnd0_is_reg = 1'b1;
      end
      FORM_RM, FORM_RM_REG, FORM_RM_IMM: begin
        if (rm_is_reg) begin
          opnd0_regsel = rm_reg;
          opnd0_is_reg = 1'b1;
        end
      end
      FORM_REG_RM: begin
        opnd0_regsel = reg_field;
        opnd0_is_reg = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb begin
    opnd1_regsel = REG_EAX;
    opnd1_is_reg = 1'b0;
    case (opnd_form)
      FORM_EAX_REG: begin
        opnd1_regsel = op_reg;
        opnd1_is_reg = 1'b1;
      end
      FORM_RM_REG: begin
        opnd1_regsel = reg_field;
        opnd1_is_reg = 1'b1;
      end
      // Memory r/m here is resolved by the address unit
      FORM_REG_RM: begin
        opnd1_regsel = rm_reg;
        opnd1_is_reg = rm_is_reg;
      end
      default: ;
    endcase
  end

  assign opnd0_regval = reg_read(opnd0_regsel, eax, ecx, edx, ebx, esp, ebp, esi, edi);
  assign opnd1_regval = reg_read(opnd1_regsel, eax, ecx, edx, ebx, esp, ebp, esi, edi);

endmodule

/* source/effective_address_unit.sv */
`timescale 1ns/10ps

module effective_address_unit
  import x86_opnd_pkg::*;
#(
  parameter int NUM_HINTS = 2
) (
  input  logic [7:0]                      modrm,
  input  logic [7:0]                      sib,
  input  logic [WORD_W-1:0]               disp,
  input  logic                            has_sib,
  input  logic                            rm_is_mem,
  input  logic [WORD_W-1:0]               eax,
  input  logic [WORD_W-1:0]               ecx,
  input  logic [WORD_W-1:0]               edx,
  input  logic [WORD_W-1:0]               ebx,
  input  logic [WORD_W-1:0]               esp,
  input  logic [WORD_W-1:0]               ebp,
  input  logic [WORD_W-1:0]               esi,
  input  logic [WORD_W-1:0]               edi,
  input  logic [NUM_HINTS-1:0]            hint_is_write,
  input  logic [NUM_HINTS-1:0][WORD_W-1:0] hint_address,
  input  logic [NUM_HINTS-1:0][WORD_W-1:0] hint_data,
  output logic [WORD_W-1:0]               mem_addr_c,
  output logic [WORD_W-1:0]               mem_val
);

  reg_sel_e          base_sel;
  reg_sel_e          index_sel;
  logic              base_used;
  logic              index_used;
  logic [1:0]        scale;
  logic [WORD_W-1:0] base_val;
  logic [WORD_W-1:0] index_val;

  always_comb begin
    if (has_sib) begin
      base_sel = reg_sel_e'(sib[2:0]);
      index_sel = reg_sel_e'(sib[5:3]);
      scale = sib[7:6];
      // Base 101 under mod 00 means disp32 takes the place of the base
      base_used = !(sib[2:0] == 3'b101 && modrm[7:6] == 2'b00);
      // ESP can never be an index, so 100 encodes no index at all
      index_used = (sib[5:3] != 3'b100);
    end else begin
      base_sel = reg_sel_e'(modrm[2:0]);
      index_sel = REG_EAX;
      scale = 2'b00;
      base_used = !(modrm[7:6] == 2'b00 && modrm[2:0] == 3'b101);
      index_used = 1'b0;
    end
  end

  assign base_val = base_used ?
    reg_read(base_sel, eax, ecx, edx, ebx, esp, ebp, esi, edi) : '0;
  assign index_val = index_used ?
    reg_read(index_sel, eax, ecx, edx, ebx, esp, ebp, esi, edi) : '0;

  // Wraps modulo 2^32 like the real AGU
  assign mem_addr_c = base_val + (index_val << scale) + disp;

  // Walk from the top so that the lowest matching hint is the one left
  always_comb begin
    mem_val = '0;
    if (rm_is_mem) begin
      for (int i = NUM_HINTS - 1; i >= 0; i--) begin
        if (!hint_is_write[i] && hint_address[i] == mem_addr_c) begin
          mem_val = hint_data[i];
        end
      end
    end
  end

  // The parser only signals a SIB byte behind a memory ModR/M
  always_comb begin
    assert (!has_sib || rm_is_mem)
      else $error("SIB byte reported for a register-direct operand");
  end

endmodule

/* source/operand_result_stage.sv */
`timescale 1ns/10ps

module operand_result_stage
  import x86_opnd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  instr_valid,
  input  opnd_form_e            opnd_form,
  input  logic                  rm_is_mem,
  input  reg_sel_e              opnd0_regsel,
  input  reg_sel_e              opnd1_regsel,
  input  logic                  opnd0_is_reg,
  input  logic                  opnd1_is_reg,
  input  logic [WORD_W-1:0]     opnd0_regval,
  input  logic [WORD_W-1:0]     opnd1_regval,
  input  logic [WORD_W-1:0]     imm,
  input  logic [WORD_W-1:0]     mem_addr_c,
  input  logic [WORD_W-1:0]     mem_val,
  input  logic [BODY_LEN_W-1:0] body_len_c,
  input  logic                  opnd0_is_write,
  input  logic                  opnd1_is_write,
  output logic                  opnd_valid,
  output logic [WORD_W-1:0]     opnd0,
  output logic [WORD_W-1:0]     opnd1,
  output logic [WORD_W-1:0]     mem_addr,
  output dest_kind_e            dest0_kind,
  output dest_kind_e            dest1_kind,
  output reg_sel_e              dest0_sel,
  output reg_sel_e              dest1_sel,
  output logic [BODY_LEN_W-1:0] body_len
);

  logic              opnd0_is_mem;
  logic              opnd1_is_mem;
  logic              opnd0_is_imm;
  logic              opnd1_is_imm;
  logic [WORD_W-1:0] opnd0_c;
  logic [WORD_W-1:0] opnd1_c;
  dest_kind_e        dest0_kind_c;
  dest_kind_e        dest1_kind_c;

  // Operand 0 reads memory whenever r/m does and no register won first
  assign opnd0_is_mem = !opnd0_is_reg && rm_is_mem;
  assign opnd1_is_mem = !opnd1_is_reg && rm_is_mem && (opnd_form == FORM_REG_RM);
  assign opnd0_is_imm = (opnd_form == FORM_IMM);
  assign opnd1_is_imm = opnd_form inside {FORM_REG_IMM, FORM_EAX_IMM, FORM_RM_IMM};

  assign opnd0_c = opnd0_is_reg ? opnd0_regval :
                   opnd0_is_mem ? mem_val      :
                   opnd0_is_imm ? imm          : '0;
  assign opnd1_c = opnd1_is_reg ? opnd1_regval :
                   opnd1_is_mem ? mem_val      :
                   opnd1_is_imm ? imm          : '0;

  // Only a written operand has a destination and an immediate never has one
  assign dest0_kind_c = !opnd0_is_write ? DEST_NONE :
                        opnd0_is_reg    ? DEST_REG  :
                        opnd0_is_mem    ? DEST_MEM  : DEST_NONE;
  assign dest1_kind_c = !opnd1_is_write ? DEST_NONE :
                        opnd1_is_reg    ? DEST_REG  :
                        opnd1_is_mem    ? DEST_MEM  : DEST_NONE;

  always_ff @(posedge clk) begin
    if (rst) begin
      opnd_valid <= 1'b0;
      opnd0 <= '0;
      opnd1 <= '0;
      mem_addr <= '0;
      dest0_kind <= DEST_NONE;
      dest1_kind <= DEST_NONE;
      dest0_sel <= REG_EAX;
      dest1_sel <= REG_EAX;
      body_len <= '0;
    end else begin
      opnd_valid <= instr_valid;
      // Results hold until the next strobe
      if (instr_valid) begin
        opnd0 <= opnd0_c;
        opnd1 <= opnd1_c;
        mem_addr <= rm_is_mem ? mem_addr_c : '0;
        dest0_kind <= dest0_kind_c;
        dest1_kind <= dest1_kind_c;
        dest0_sel <= (dest0_kind_c == DEST_REG) ? opnd0_regsel : REG_EAX;
        dest1_sel <= (dest1_kind_c == DEST_REG) ? opnd1_regsel : REG_EAX;
        body_len <= body_len_c;
      end
    end
  end

  // An x86 instruction names memory through r/m at most once
  a_one_mem_opnd: assert property (@(posedge clk) disable iff (rst)
    instr_valid |-> !(opnd0_is_mem && opnd1_is_mem));

endmodule

/* source/x86_opnd_decode.sv */
`timescale 1ns/10ps

module x86_opnd_decode
  import x86_opnd_pkg::*;
#(
  parameter int NUM_HINTS = 2
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            instr_valid,
  input  logic [INSTR_BYTES*8-1:0]        instr_bytes,
  input  opnd_form_e                      opnd_form,
  input  logic                            imm_1byte,
  input  logic                            opnd0_is_write,
  input  logic                            opnd1_is_write,
  input  logic [WORD_W-1:0]               eax,
  input  logic [WORD_W-1:0]               ecx,
  input  logic [WORD_W-1:0]               edx,
  input  logic [WORD_W-1:0]               ebx,
  input  logic [WORD_W-1:0]               esp,
  input  logic [WORD_W-1:0]               ebp,
  input  logic [WORD_W-1:0]               esi,
  input  logic [WORD_W-1:0]               edi,
  input  logic [NUM_HINTS-1:0]            hint_is_write,
  input  logic [NUM_HINTS-1:0][WORD_W-1:0] hint_address,
  input  logic [NUM_HINTS-1:0][WORD_W-1:0] hint_data,
  output logic                            opnd_valid,
  output logic [WORD_W-1:0]               opnd0,
  output logic [WORD_W-1:0]               opnd1,
  output logic [WORD_W-1:0]               mem_addr,
  output dest_kind_e                      dest0_kind,
  output dest_kind_e                      dest1_kind,
  output reg_sel_e                        dest0_sel,
  output reg_sel_e                        dest1_sel,
  output logic [BODY_LEN_W-1:0]           body_len
);

  // Parsed instruction fields
  logic [7:0]            modrm;
  logic [7:0]            sib;
  logic [WORD_W-1:0]     disp;
  logic [WORD_W-1:0]     imm;
  logic                  has_sib;
  logic                  rm_is_reg;
  logic                  rm_is_mem;
  logic [BODY_LEN_W-1:0] body_len_c;

  // Register operand candidates
  reg_sel_e              opnd0_regsel;
  reg_sel_e              opnd1_regsel;
  logic                  opnd0_is_reg;
  logic                  opnd1_is_reg;
  logic [WORD_W-1:0]     opnd0_regval;
  logic [WORD_W-1:0]     opnd1_regval;

  // One AGU, since only r/m can name memory
  logic [WORD_W-1:0]     mem_addr_c;
  logic [WORD_W-1:0]     mem_val;

  instr_field_parser parser_i (
    .body_len(body_len_c),
    .*
  );

  reg_operand_select regsel_i (
    .opcode_low(instr_bytes[2:0]),
    .*
  );

  effective_address_unit #(
    .NUM_HINTS(NUM_HINTS)
  ) agu_i (
    .*
  );

  // Everything above settles in the strobe cycle and is captured here
  operand_result_stage result_i (
    .*
  );

endmodule

/* include/opnd_ref_model.svh */
`ifndef OPND_REF_MODEL_SVH
`define OPND_REF_MODEL_SVH

// The including module imports x86_opnd_pkg, the model uses its types directly

// Everything the DUT reports for one strobe
typedef struct packed {
  logic [31:0] opnd0;
  logic [31:0] opnd1;
  logic [31:0] mem_addr;
  dest_kind_e  dest0_kind;
  dest_kind_e  dest1_kind;
  reg_sel_e    dest0_sel;
  reg_sel_e    dest1_sel;
  logic [3:0]  body_len;
} opnd_exp_t;

// Little-endian field of len bytes at byte pos, a single byte is sign-extended
function automatic logic [31:0] ref_field(input logic [87:0] bytes, input int pos,
                                          input int len);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < len; i++) begin
    v[8*i +: 8] = bytes[8*(pos + i) +: 8];
  end
  if (len == 1) begin
    v = {{24{v[7]}}, v[7:0]};
  end
  return v;
endfunction

function automatic opnd_exp_t ref_model(
  input logic [87:0]      bytes,
  input opnd_form_e       form,
  input logic             imm_1byte,
  input logic             w0,
  input logic             w1,
  input logic [7:0][31:0] regs,
  input logic [1:0]       hint_wr,
  input logic [1:0][31:0] hint_addr,
  input logic [1:0][31:0] hint_data
);
  opnd_exp_t   e;
  logic        has_modrm;
  logic        mem;
  logic        has_sib;
  logic        is_reg0;
  logic        is_reg1;
  logic        mem1;
  logic [7:0]  modrm;
  logic [7:0]  sib;
  logic [2:0]  sel0;
  logic [2:0]  sel1;
  logic [31:0] disp;
  logic [31:0] imm;
  logic [31:0] base;
  logic [31:0] index;
  logic [31:0] memval;
  int          pos;
  int          dlen;
  e = '0;
  has_modrm = form inside {FORM_RM, FORM_RM_REG, FORM_REG_RM, FORM_RM_IMM};
  modrm = bytes[15:8];
  sib = bytes[23:16];
  mem = has_modrm && modrm[7:6] != 2'b11;
  has_sib = mem && modrm[2:0] == 3'b100;
  pos = 1 + int'(has_modrm) + int'(has_sib);
  dlen = 0;
  if (mem && modrm[7:6] == 2'b01) begin
    dlen = 1;
  end else if (mem && (modrm[7:6] == 2'b10 ||
                       (has_sib ? sib[2:0] : modrm[2:0]) == 3'b101)) begin
    dlen = 4;
  end
  disp = (dlen == 0) ? '0 : ref_field(bytes, pos, dlen);
  pos += dlen;
  imm = '0;
  if (form inside {FORM_IMM, FORM_REG_IMM, FORM_EAX_IMM, FORM_RM_IMM}) begin
    imm = ref_field(bytes, pos, imm_1byte ? 1 : 4);
    pos += imm_1byte ? 1 : 4;
  end
  e.body_len = 4'(pos - 1);

  if (has_sib) begin
    base = (sib[2:0] == 3'b101 && modrm[7:6] == 2'b00) ? '0 : regs[sib[2:0]];
    index = (sib[5:3] == 3'b100) ? '0 : regs[sib[5:3]] << sib[7:6];
  end else begin
    base = (modrm[7:6] == 2'b00 && modrm[2:0] == 3'b101) ? '0 : regs[modrm[2:0]];
    index = '0;
  end
  if (mem) begin
    e.mem_addr = base + index + disp;
  end
  memval = '0;
  for (int i = 1; i >= 0; i--) begin
    if (mem && !hint_wr[i] && hint_addr[i] == e.mem_addr) begin
      memval = hint_data[i];
    end
  end

  is_reg0 = 1'b1;
  sel0 = 3'd0;
  case (form)
    FORM_REG, FORM_REG_IMM: sel0 = bytes[2:0];
    FORM_EAX_IMM, FORM_EAX_REG: sel0 = 3'd0;
    FORM_REG_RM: sel0 = modrm[5:3];
    FORM_RM, FORM_RM_REG, FORM_RM_IMM: begin
      is_reg0 = !mem;
      sel0 = modrm[2:0];
    end
    default: is_reg0 = 1'b0;
  endcase
  is_reg1 = 1'b1;
  sel1 = 3'd0;
  case (form)
    FORM_EAX_REG: sel1 = bytes[2:0];
    FORM_RM_REG: sel1 = modrm[5:3];
    FORM_REG_RM: begin
      is_reg1 = !mem;
      sel1 = modrm[2:0];
    end
    default: is_reg1 = 1'b0;
  endcase
  mem1 = (form == FORM_REG_RM) && mem;

  e.opnd0 = is_reg0 ? regs[sel0] : mem ? memval : (form == FORM_IMM) ? imm : '0;
  e.opnd1 = is_reg1 ? regs[sel1] : mem1 ? memval :
            (form inside {FORM_REG_IMM, FORM_EAX_IMM, FORM_RM_IMM}) ? imm : '0;
  e.dest0_kind = !w0 ? DEST_NONE : is_reg0 ? DEST_REG : mem ? DEST_MEM : DEST_NONE;
  e.dest1_kind = !w1 ? DEST_NONE : is_reg1 ? DEST_REG : mem1 ? DEST_MEM : DEST_NONE;
  e.dest0_sel = (e.dest0_kind == DEST_REG) ? reg_sel_e'(sel0) : REG_EAX;
  e.dest1_sel = (e.dest1_kind == DEST_REG) ? reg_sel_e'(sel1) : REG_EAX;
  return e;
endfunction

`endif

/* testbench/tb_x86_opnd_decode.sv */
`timescale 1ns/10ps

module tb_x86_opnd_decode
  import x86_opnd_pkg::*;
();

  `include "opnd_ref_model.svh"

  localparam int NUM_STROBES = 2000;
  // Two cycles per strobe at worst, plus reset and drain margin
  localparam int CYCLE_LIMIT = 4100;

  // One outstanding instruction waiting for its result
  typedef struct {
    opnd_exp_t  exp;
    opnd_form_e form;
    int         cycle;
  } pending_t;

  logic                       clk;
  logic                       rst;
  logic                       instr_valid;
  logic [INSTR_BYTES*8-1:0]   instr_bytes;
  opnd_form_e                 opnd_form;
  logic                       imm_1byte;
  logic                       opnd0_is_write;
  logic                       opnd1_is_write;
  logic [7:0][WORD_W-1:0]     regs;
  logic [1:0]                 hint_is_write;
  logic [1:0][WORD_W-1:0]     hint_address;
  logic [1:0][WORD_W-1:0]     hint_data;
  logic                       opnd_valid;
  logic [WORD_W-1:0]          opnd0;
  logic [WORD_W-1:0]          opnd1;
  logic [WORD_W-1:0]          mem_addr;
  dest_kind_e                 dest0_kind;
  dest_kind_e                 dest1_kind;
  reg_sel_e                   dest0_sel;
  reg_sel_e                   dest1_sel;
  logic [BODY_LEN_W-1:0]      body_len;

  logic [31:0] lfsr_state = 32'd33;
  int          cycle = 0;
  int          sent = 0;
  int          checks = 0;
  int          errors = 0;
  pending_t    pend_q[$];
  pending_t    popped;
  opnd_exp_t   held = '0;
  opnd_form_e  last_form;
  string       cur_name = "reset state";
  logic        seen_result = 1'b0;

  x86_opnd_decode #(
    .NUM_HINTS(2)
  ) dut_i (
    .clk(clk),
    .rst(rst),
    .instr_valid(instr_valid),
    .instr_bytes(instr_bytes),
    .opnd_form(opnd_form),
    .imm_1byte(imm_1byte),
    .opnd0_is_write(opnd0_is_write),
    .opnd1_is_write(opnd1_is_write),
    .eax(regs[0]),
    .ecx(regs[1]),
    .edx(regs[2]),
    .ebx(regs[3]),
    .esp(regs[4]),
    .ebp(regs[5]),
    .esi(regs[6]),
    .edi(regs[7]),
    .hint_is_write(hint_is_write),
    .hint_address(hint_address),
    .hint_data(hint_data),
    .opnd_valid(opnd_valid),
    .opnd0(opnd0),
    .opnd1(opnd1),
    .mem_addr(mem_addr),
    .dest0_kind(dest0_kind),
    .dest1_kind(dest1_kind),
    .dest0_sel(dest0_sel),
    .dest1_sel(dest1_sel),
    .body_len(body_len)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic compare_outputs(input string name, input opnd_exp_t e);
    check_value({name, " opnd0"}, e.opnd0, opnd0);
    check_value({name, " opnd1"}, e.opnd1, opnd1);
    check_value({name, " mem_addr"}, e.mem_addr, mem_addr);
    check_value({name, " dest0_kind"}, 32'(e.dest0_kind), 32'(dest0_kind));
    check_value({name, " dest1_kind"}, 32'(e.dest1_kind), 32'(dest1_kind));
    check_value({name, " dest0_sel"}, 32'(e.dest0_sel), 32'(dest0_sel));
    check_value({name, " dest1_sel"}, 32'(e.dest1_sel), 32'(dest1_sel));
    check_value({name, " body_len"}, 32'(e.body_len), 32'(body_len));
  endtask

  // New random instruction, registers and hints on the DUT inputs
  task automatic randomize_inputs();
    opnd_exp_t  e;
    logic [3:0] fcode;
    logic [1:0] pick;
    for (int i = 0; i < INSTR_BYTES; i++) begin
      instr_bytes[8*i +: 8] = 8'(rand_bits(8));
    end
    fcode = 4'(rand_bits(4) % 32'd10);
    opnd_form = opnd_form_e'(fcode);
    imm_1byte = rand_bits(1) != 0;
    opnd0_is_write = rand_bits(1) != 0;
    opnd1_is_write = rand_bits(1) != 0;
    for (int i = 0; i < 8; i++) begin
      regs[i] = rand_bits(32);
    end
    for (int i = 0; i < 2; i++) begin
      hint_is_write[i] = rand_bits(1) != 0;
      hint_address[i] = rand_bits(32);
      hint_data[i] = rand_bits(32);
    end
    e = ref_model(instr_bytes, opnd_form, imm_1byte, opnd0_is_write, opnd1_is_write,
                  regs, hint_is_write, hint_address, hint_data);
    // About half the time aim hint 0, hint 1 or both at the real address
    if (rand_bits(1) != 0) begin
      pick = 2'(rand_bits(2));
      if (pick != 2'd2) begin
        hint_address[0] = e.mem_addr;
      end
      if (pick != 2'd1) begin
        hint_address[1] = e.mem_addr;
      end
    end
  endtask

  // Outputs are stable at the falling edge, half a cycle after any update
  always @(negedge clk) begin
    if (!rst) begin
      if (opnd_valid) begin
        if (pend_q.size() == 0) begin
          errors++;
          $display("opnd_valid was high at cycle %0d with no instruction outstanding", cycle);
        end else begin
          popped = pend_q.pop_front();
          held = popped.exp;
          last_form = popped.form;
          cur_name = last_form.name();
          seen_result = 1'b1;
          // Results must come exactly one cycle after their strobe
          check_value({cur_name, " latency"}, 32'd1, 32'(cycle - popped.cycle));
        end
      end else if (seen_result) begin
        cur_name = "hold";
      end
      // Between strobes the last result, or the reset values, must stay put
      compare_outputs(cur_name, held);
    end
  end

  initial begin
    pending_t p;
    rst = 1'b1;
    instr_valid = 1'b0;
    instr_bytes = '0;
    opnd_form = FORM_NONE;
    imm_1byte = 1'b0;
    opnd0_is_write = 1'b0;
    opnd1_is_write = 1'b0;
    regs = '0;
    hint_is_write = '0;
    hint_address = '0;
    hint_data = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    // A few quiet cycles so the reset state gets checked
    repeat (3) begin
      @(posedge clk);
      #1;
    end
    while (sent < NUM_STROBES) begin
      // Random gaps, otherwise strobes run back to back
      if (rand_bits(1) != 0) begin
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        randomize_inputs();
      end
      @(posedge clk);
      #1;
      randomize_inputs();
      instr_valid = 1'b1;
      p.exp = ref_model(instr_bytes, opnd_form, imm_1byte, opnd0_is_write,
                        opnd1_is_write, regs, hint_is_write, hint_address, hint_data);
      p.form = opnd_form;
      p.cycle = cycle;
      pend_q.push_back(p);
      sent++;
    end
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    if (pend_q.size() != 0) begin
      errors++;
      $display("%0d results never came back from the DUT", pend_q.size());
    end
    $display("strobes %0d, checks %0d, errors %0d", sent, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Stops a run that fails to get through all strobes in time
  initial begin
    while (cycle < CYCLE_LIMIT) begin
      @(posedge clk);
    end
    $display("timeout at cycle %0d before the run completed", cycle);
    $display("strobes %0d, checks %0d, errors %0d", sent, checks, errors);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* x86_opnd_decode.f */
+incdir+include
source/x86_opnd_pkg.sv
source/instr_field_parser.sv
source/reg_operand_select.sv
source/effective_address_unit.sv
source/operand_result_stage.sv
source/x86_opnd_decode.sv
testbench/tb_x86_opnd_decode.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the operand decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_x86_opnd_decode \
  -f x86_opnd_decode.f \
  -o sim_tb_x86_opnd_decode
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb_x86_opnd_decode)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qxF '** PASS **'; then
  exit 0
fi
exit 1
